// ==== dma_consts.svh ====
`ifndef DMA_CONSTS_SVH
`define DMA_CONSTS_SVH

// Address width for source and destination
`define DMA_ADDR_WIDTH 32

// Byte count of a whole transfer
`define DMA_TRAN_SIZE_WIDTH 23

// Byte count of one AXI burst, up to 4 KB
`define DMA_AXI_SIZE_WIDTH 13

// Internal descriptor number
`define DMA_INT_BDS_WIDTH 2

// Queue credits after reset and the counter width
`define DMA_QUEUE_CREDITS 2
`define DMA_CREDIT_WIDTH 2

`endif

// ==== dmaPkg.sv ====
`include "dma_consts.svh"

package dmaPkg;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    // Address operation of one side of a transfer
    typedef enum logic [1:0]
    {
        OP_NONE  = 2'd0,
        OP_INCR  = 2'd1,
        OP_FIXED = 2'd2,
        OP_RSVD  = 2'd3
    } addrOp_e;

    // Acknowledge sequencer states
    typedef enum logic [1:0]
    {
        IDLE,
        WAIT_TRANS_RDY,
        WAIT_INT_FETCH
    } ackState_e;

    //////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////

    // Current operation from the transaction queues
    typedef struct packed
    {
        addrOp_e                         srcOp;
        addrOp_e                         dstOp;
        logic [`DMA_ADDR_WIDTH-1:0]      srcAddr;
        logic [`DMA_ADDR_WIDTH-1:0]      dstAddr;
        logic [`DMA_TRAN_SIZE_WIDTH-1:0] numOfBytes;
    } dmaOp_t;

    // Descriptor flags
    typedef struct packed
    {
        logic                          chain;
        logic                          extDscrptr;
        logic                          extDscrptrNxt;
        logic [`DMA_INT_BDS_WIDTH-1:0] nxtIntDscrptrNum;
    } descInfo_t;

    // Status from the read controller
    typedef struct packed
    {
        logic                           rdyToAck;
        logic                           extDataValid;
        logic [`DMA_AXI_SIZE_WIDTH-1:0] srcAxiNumOfBytes;
    } rdStatus_t;

    // Operation published with the acknowledge
    typedef struct packed
    {
        logic                            extDataValid;
        logic [`DMA_TRAN_SIZE_WIDTH-1:0] numOfBytes;
        logic [`DMA_ADDR_WIDTH-1:0]      srcAddr;
        logic [`DMA_ADDR_WIDTH-1:0]      dstAddr;
    } ackResult_t;

endpackage

// ==== queueCredits.sv ====
`timescale 1ns/1ps

`include "dma_consts.svh"

module queueCredits
(
    input  logic clock,
    input  logic resetn,
    input  logic creditTake,
    input  logic rdCreditReturn,
    input  logic wrCreditReturn,
    output logic hasCredit
);

    localparam logic [`DMA_CREDIT_WIDTH-1:0] maxCredits =
        `DMA_CREDIT_WIDTH'(`DMA_QUEUE_CREDITS);

    logic [`DMA_CREDIT_WIDTH-1:0] rdCredits;
    logic [`DMA_CREDIT_WIDTH-1:0] wrCredits;

    // One counter step, shared by both queues
    function automatic logic [`DMA_CREDIT_WIDTH-1:0] nextCount
    (
        input logic [`DMA_CREDIT_WIDTH-1:0] count,
        input logic                         take,
        input logic                         giveBack
    );
        logic [`DMA_CREDIT_WIDTH-1:0] next;
        next = count;
        if (take && !giveBack)
        begin
            next = count - 1'b1;
        end
        else if (giveBack && !take && (count != maxCredits))
        begin
            // Saturate at the reset level
            next = count + 1'b1;
        end
        return next;
    endfunction

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            rdCredits <= maxCredits;
            wrCredits <= maxCredits;
        end
        else
        begin
            rdCredits <= nextCount(rdCredits, creditTake, rdCreditReturn);
            wrCredits <= nextCount(wrCredits, creditTake, wrCreditReturn);
        end
    end

    // Both queues must be able to take another transaction
    assign hasCredit = (rdCredits != '0) && (wrCredits != '0);

endmodule

// ==== opUpdate.sv ====
`timescale 1ns/1ps

`include "dma_consts.svh"

module opUpdate
(
    input  logic               clock,
    input  logic               resetn,
    input  dmaPkg::dmaOp_t     op,
    input  dmaPkg::descInfo_t  desc,
    input  dmaPkg::rdStatus_t  rdStatus,
    input  logic               resultLoad,
    output logic               chunkDone,
    output dmaPkg::ackResult_t result
);

    import dmaPkg::*;

    logic [`DMA_TRAN_SIZE_WIDTH-1:0] axiBytes;
    logic [`DMA_ADDR_WIDTH-1:0]      axiStep;
    ackResult_t                      nextResult;

    // Burst size widened to the count and address widths
    assign axiBytes = {{(`DMA_TRAN_SIZE_WIDTH - `DMA_AXI_SIZE_WIDTH){1'b0}},
                       rdStatus.srcAxiNumOfBytes};
    assign axiStep  = {{(`DMA_ADDR_WIDTH - `DMA_AXI_SIZE_WIDTH){1'b0}},
                       rdStatus.srcAxiNumOfBytes};

    //////////////////////////////////////////////////
    // Next-chunk operation
    //////////////////////////////////////////////////

    always_comb
    begin
        nextResult.extDataValid = rdStatus.extDataValid;

        // Normal chunk, one burst consumed
        nextResult.numOfBytes = op.numOfBytes - axiBytes;
        if (op.srcOp == OP_INCR)
        begin
            nextResult.srcAddr = op.srcAddr + axiStep;
        end
        else
        begin
            nextResult.srcAddr = op.srcAddr;
        end
        if (op.dstOp == OP_INCR)
        begin
            nextResult.dstAddr = op.dstAddr + axiStep;
        end
        else
        begin
            nextResult.dstAddr = op.dstAddr;
        end
        chunkDone = (op.numOfBytes == axiBytes);

        if (op.srcOp == OP_NONE)
        begin
            // Nothing to move, descriptor is finished
            nextResult.numOfBytes = '0;
            nextResult.srcAddr    = op.srcAddr;
            nextResult.dstAddr    = op.dstAddr;
            chunkDone             = 1'b1;
        end
        else if (desc.extDscrptr && !rdStatus.extDataValid)
        begin
            // No data moved, operation stays as it was
            nextResult.numOfBytes = op.numOfBytes;
            nextResult.srcAddr    = op.srcAddr;
            nextResult.dstAddr    = op.dstAddr;
            chunkDone             = 1'b0;
        end
    end

    // Result holds between acknowledges
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            result <= '0;
        end
        else if (resultLoad)
        begin
            result <= nextResult;
        end
    end

endmodule

// ==== transAckSeq.sv ====
`timescale 1ns/1ps

`include "dma_consts.svh"

module transAckSeq
(
    input  logic                          clock,
    input  logic                          resetn,
    input  logic                          doTrans,
    input  logic                          hasCredit,
    input  logic                          rdyToAck,
    input  dmaPkg::descInfo_t             desc,
    input  logic                          chunkDone,
    input  logic                          intFetchAck,
    output logic                          creditTake,
    output logic                          resultLoad,
    output logic                          transAck,
    output logic                          fetchIntDscrptr,
    output logic [`DMA_INT_BDS_WIDTH-1:0] intDscrptrNum
);

    import dmaPkg::*;

    ackState_e state;
    ackState_e nextState;
    logic      fetchNeeded;

    //////////////////////////////////////////////////
    // Handshake decode
    //////////////////////////////////////////////////

    // Admit a new transfer. doTrans is still high during the ack cycle
    assign creditTake = (state == IDLE) && doTrans && hasCredit && !transAck;

    // Read side is ready, publish the next operation
    assign resultLoad = (state == WAIT_TRANS_RDY) && rdyToAck;

    // Chained internal descriptor has finished
    assign fetchNeeded = chunkDone && desc.chain && !desc.extDscrptrNxt;

    // Fetch request is held for the whole wait state
    assign fetchIntDscrptr = (state == WAIT_INT_FETCH);

    //////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////

    always_comb
    begin
        nextState = state;
        case (state)
            IDLE:
            begin
                if (creditTake)
                begin
                    nextState = WAIT_TRANS_RDY;
                end
            end
            WAIT_TRANS_RDY:
            begin
                if (resultLoad)
                begin
                    nextState = fetchNeeded ? WAIT_INT_FETCH : IDLE;
                end
            end
            WAIT_INT_FETCH:
            begin
                if (intFetchAck)
                begin
                    nextState = IDLE;
                end
            end
            default:
            begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            state    <= IDLE;
            transAck <= 1'b0;
        end
        else
        begin
            state    <= nextState;
            // One-cycle pulse, aligned with the result update
            transAck <= resultLoad;
        end
    end

    // Next descriptor number captured with the acknowledge
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            intDscrptrNum <= '0;
        end
        else if (resultLoad && fetchNeeded)
        begin
            intDscrptrNum <= desc.nxtIntDscrptrNum;
        end
    end

endmodule

// ==== dmaTransAck.sv ====
`timescale 1ns/1ps

`include "dma_consts.svh"

module dmaTransAck
(
    input  logic                          clock,
    input  logic                          resetn,
    input  logic                          doTrans,
    input  dmaPkg::dmaOp_t                op,
    input  dmaPkg::descInfo_t             desc,
    input  dmaPkg::rdStatus_t             rdStatus,
    input  logic                          rdCreditReturn,
    input  logic                          wrCreditReturn,
    input  logic                          intFetchAck,
    output logic                          transAck,
    output dmaPkg::ackResult_t            result,
    output logic                          fetchIntDscrptr,
    output logic [`DMA_INT_BDS_WIDTH-1:0] intDscrptrNum
);

    logic hasCredit;
    logic creditTake;
    logic resultLoad;
    logic chunkDone;

    // Queue space tracking
    queueCredits i_credits
    (
        .clock          (clock),
        .resetn         (resetn),
        .creditTake     (creditTake),
        .rdCreditReturn (rdCreditReturn),
        .wrCreditReturn (wrCreditReturn),
        .hasCredit      (hasCredit)
    );

    // Next-chunk datapath
    opUpdate i_opUpdate
    (
        .clock      (clock),
        .resetn     (resetn),
        .op         (op),
        .desc       (desc),
        .rdStatus   (rdStatus),
        .resultLoad (resultLoad),
        .chunkDone  (chunkDone),
        .result     (result)
    );

    // Acknowledge sequencer
    transAckSeq i_seq
    (
        .clock           (clock),
        .resetn          (resetn),
        .doTrans         (doTrans),
        .hasCredit       (hasCredit),
        .rdyToAck        (rdStatus.rdyToAck),
        .desc            (desc),
        .chunkDone       (chunkDone),
        .intFetchAck     (intFetchAck),
        .creditTake      (creditTake),
        .resultLoad      (resultLoad),
        .transAck        (transAck),
        .fetchIntDscrptr (fetchIntDscrptr),
        .intDscrptrNum   (intDscrptrNum)
    );

endmodule

// ==== tb_dmaTransAck.sv ====
`timescale 1ns/1ps

`include "dma_consts.svh"

module tb_dmaTransAck;

    import dmaPkg::*;

    localparam int CLOCK_PERIOD = 100;
    localparam int MAX_VECTORS  = 64;
    localparam int ACK_TIMEOUT  = 20;

    logic                          clock;
    logic                          resetn;
    logic                          doTrans;
    dmaOp_t                        op;
    descInfo_t                     desc;
    rdStatus_t                     rdStatus;
    logic                          rdCreditReturn;
    logic                          wrCreditReturn;
    logic                          intFetchAck;
    logic                          transAck;
    ackResult_t                    result;
    logic                          fetchIntDscrptr;
    logic [`DMA_INT_BDS_WIDTH-1:0] intDscrptrNum;

    // One entry per data line
    dmaOp_t                        vecOp      [0:MAX_VECTORS-1];
    descInfo_t                     vecDesc    [0:MAX_VECTORS-1];
    rdStatus_t                     vecRd      [0:MAX_VECTORS-1];
    int                            vecReturns [0:MAX_VECTORS-1];
    ackResult_t                    vecExp     [0:MAX_VECTORS-1];
    logic                          vecFetch   [0:MAX_VECTORS-1];
    logic [`DMA_INT_BDS_WIDTH-1:0] vecFetchNum[0:MAX_VECTORS-1];

    int     vecCount;
    int     vecIdx;
    int     errors;
    int     checks;
    // Expected queue credits, both queues move together here
    int     credits;
    integer seed;
    bit     loaded;

    dmaTransAck i_dut
    (
        .clock           (clock),
        .resetn          (resetn),
        .doTrans         (doTrans),
        .op              (op),
        .desc            (desc),
        .rdStatus        (rdStatus),
        .rdCreditReturn  (rdCreditReturn),
        .wrCreditReturn  (wrCreditReturn),
        .intFetchAck     (intFetchAck),
        .transAck        (transAck),
        .result          (result),
        .fetchIntDscrptr (fetchIntDscrptr),
        .intDscrptrNum   (intDscrptrNum)
    );

    initial
    begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    // Watchdog, scaled by the number of vectors
    initial
    begin
        wait (loaded);
        #((vecCount * 20 + 50) * CLOCK_PERIOD);
        $display("Watchdog expired, the run did not finish in %0d clock periods",
                 vecCount * 20 + 50);
        $display("Test FAILED");
        $finish;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // Drive point sits 10 ns after the rising edge
    task automatic nextCycle();
        @(posedge clock);
        #10;
    endtask

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        checks++;
        if (actual !== expected)
        begin
            $display("** Error: %s expected %h, got %h (vector %0d)",
                     name, expected, actual, vecIdx + 1);
            errors++;
        end
    endtask

    task automatic checkResult(input int idx);
        checkValue("result.numOfBytes", vecExp[idx].numOfBytes, result.numOfBytes);
        checkValue("result.srcAddr", vecExp[idx].srcAddr, result.srcAddr);
        checkValue("result.dstAddr", vecExp[idx].dstAddr, result.dstAddr);
        checkValue("result.extDataValid", vecExp[idx].extDataValid, result.extDataValid);
    endtask

    task automatic loadVectors();
        int          fd;
        int          n;
        string       text;
        logic [31:0] fld [0:17];
        fd = $fopen("dma_testdata.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open dma_testdata.txt");
            errors++;
        end
        else
        begin
            while (!$feof(fd) && vecCount < MAX_VECTORS)
            begin
                text = "";
                n = $fgets(text, fd);
                if (n > 0 && text.getc(0) != "#")
                begin
                    n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                fld[0], fld[1], fld[2], fld[3], fld[4], fld[5],
                                fld[6], fld[7], fld[8], fld[9], fld[10], fld[11],
                                fld[12], fld[13], fld[14], fld[15], fld[16], fld[17]);
                    if (n == 18)
                    begin
                        vecOp[vecCount].srcOp      = addrOp_e'(fld[0][1:0]);
                        vecOp[vecCount].dstOp      = addrOp_e'(fld[1][1:0]);
                        vecOp[vecCount].srcAddr    = fld[2];
                        vecOp[vecCount].dstAddr    = fld[3];
                        vecOp[vecCount].numOfBytes = fld[4][`DMA_TRAN_SIZE_WIDTH-1:0];
                        vecDesc[vecCount].chain            = fld[5][0];
                        vecDesc[vecCount].extDscrptr       = fld[6][0];
                        vecDesc[vecCount].extDscrptrNxt    = fld[7][0];
                        vecDesc[vecCount].nxtIntDscrptrNum = fld[8][`DMA_INT_BDS_WIDTH-1:0];
                        vecRd[vecCount].rdyToAck         = 1'b0;
                        vecRd[vecCount].extDataValid     = fld[9][0];
                        vecRd[vecCount].srcAxiNumOfBytes = fld[10][`DMA_AXI_SIZE_WIDTH-1:0];
                        vecReturns[vecCount] = int'(fld[11]);
                        vecExp[vecCount].numOfBytes   = fld[12][`DMA_TRAN_SIZE_WIDTH-1:0];
                        vecExp[vecCount].srcAddr      = fld[13];
                        vecExp[vecCount].dstAddr      = fld[14];
                        vecExp[vecCount].extDataValid = fld[15][0];
                        vecFetch[vecCount]    = fld[16][0];
                        vecFetchNum[vecCount] = fld[17][`DMA_INT_BDS_WIDTH-1:0];
                        vecCount++;
                    end
                end
            end
            $fclose(fd);
            if (vecCount == 0)
            begin
                $display("No test vectors found in dma_testdata.txt");
                errors++;
            end
        end
    endtask

    // Return credits on both queues, one per cycle
    task automatic pulseReturns(input int count);
        if (count > 0)
        begin
            rdCreditReturn = 1'b1;
            wrCreditReturn = 1'b1;
            repeat (count) nextCycle();
            rdCreditReturn = 1'b0;
            wrCreditReturn = 1'b0;
            credits = credits + count;
            if (credits > `DMA_QUEUE_CREDITS)
            begin
                credits = `DMA_QUEUE_CREDITS;
            end
        end
    endtask

    task automatic waitForAck(input int delay, output bit seen);
        int cycles;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < ACK_TIMEOUT)
        begin
            nextCycle();
            cycles++;
            if (transAck)
            begin
                seen = 1'b1;
            end
            else if (cycles == delay)
            begin
                rdStatus.rdyToAck = 1'b1;
            end
        end
    endtask

    // Fetch pending, a new request waits with rdyToAck high
    task automatic holdDuringFetch(input int idx);
        repeat (3)
        begin
            nextCycle();
            checkValue("transAck", 0, transAck);
            checkValue("fetchIntDscrptr", 1, fetchIntDscrptr);
            checkValue("intDscrptrNum", vecFetchNum[idx], intDscrptrNum);
        end
        checkResult(idx);
        intFetchAck = 1'b1;
    endtask

    task automatic runVector(input int idx);
        int delay;
        bit seen;
        delay    = {$random(seed)} % 4;
        op       = vecOp[idx];
        desc     = vecDesc[idx];
        rdStatus = vecRd[idx];
        doTrans  = 1'b1;
        if (credits == 0)
        begin
            // Queues are full, so no admission yet
            rdStatus.rdyToAck = 1'b1;
            repeat (10)
            begin
                nextCycle();
                checkValue("transAck", 0, transAck);
            end
            pulseReturns(1);
            delay = 0;
        end
        else if (delay == 0)
        begin
            rdStatus.rdyToAck = 1'b1;
        end
        waitForAck(delay, seen);
        credits--;
        if (!seen)
        begin
            $display("Vector %0d got no transAck within %0d cycles", idx + 1, ACK_TIMEOUT);
            errors++;
        end
        else
        begin
            checkResult(idx);
            checkValue("fetchIntDscrptr", vecFetch[idx], fetchIntDscrptr);
            if (vecFetch[idx])
            begin
                checkValue("intDscrptrNum", vecFetchNum[idx], intDscrptrNum);
                holdDuringFetch(idx);
            end
        end
        // Arbiter drops the request one edge after the acknowledge
        nextCycle();
        doTrans     = 1'b0;
        intFetchAck = 1'b0;
        // Acknowledge is a single-cycle pulse
        checkValue("transAck", 0, transAck);
        checkValue("fetchIntDscrptr", 0, fetchIntDscrptr);
        nextCycle();
        rdStatus.rdyToAck = 1'b0;
        // No second admission from the request held over the ack
        checkValue("transAck", 0, transAck);
        pulseReturns(vecReturns[idx]);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        resetn         = 1'b0;
        doTrans        = 1'b0;
        op             = '0;
        desc           = '0;
        rdStatus       = '0;
        rdCreditReturn = 1'b0;
        wrCreditReturn = 1'b0;
        intFetchAck    = 1'b0;
        errors         = 0;
        checks         = 0;
        vecCount       = 0;
        vecIdx         = 0;
        loaded         = 1'b0;
        seed           = 32'h076e762f;
        credits        = `DMA_QUEUE_CREDITS;
        loadVectors();
        loaded = 1'b1;
        repeat (3) @(posedge clock);
        #10;
        resetn = 1'b1;
        checkValue("transAck", 0, transAck);
        checkValue("fetchIntDscrptr", 0, fetchIntDscrptr);
        checkValue("result.numOfBytes", 0, result.numOfBytes);
        checkValue("result.srcAddr", 0, result.srcAddr);
        checkValue("result.dstAddr", 0, result.dstAddr);
        checkValue("result.extDataValid", 0, result.extDataValid);
        for (vecIdx = 0; vecIdx < vecCount; vecIdx++)
        begin
            runVector(vecIdx);
        end
        $display("Vectors: %0d, checks: %0d, errors: %0d", vecCount, checks, errors);
        if (errors == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== dma_testdata.txt ====
# srcOp dstOp srcAddr dstAddr numOfBytes chain extDscrptr extDscrptrNxt nxtNum extDataValid axiBytes returns
# then expected: numOfBytes srcAddr dstAddr extDataValid fetch fetchNum (all hex)
1 1 00001000 80000000 004000 0 0 0 0 0 1000 1 003000 00002000 80001000 0 0 0
1 1 0000fff0 20000010 000300 1 0 0 2 0 0100 1 000200 000100f0 20000110 0 0 0
2 2 40000000 50000000 001000 0 0 0 0 0 0800 1 000800 40000000 50000000 0 0 0
3 1 12345678 00000100 000fff 0 0 0 0 0 0040 1 000fbf 12345678 00000140 0 0 0
1 3 00000200 abcdef00 000100 0 0 0 0 0 0080 1 000080 00000280 abcdef00 0 0 0
1 1 00003000 00004000 000800 1 0 0 3 0 0800 1 000000 00003800 00004800 0 1 3
2 1 00000010 00000020 000040 1 0 0 1 0 0040 1 000000 00000010 00000060 0 1 1
1 1 00005000 00006000 002000 0 1 0 0 0 1000 1 002000 00005000 00006000 0 0 0
1 1 00005000 00006000 002000 0 1 0 0 1 1000 1 001000 00006000 00007000 1 0 0
1 1 00007000 00008000 000100 1 1 0 2 0 0100 1 000100 00007000 00008000 0 0 0
0 1 00009000 0000a000 000500 1 0 1 1 0 0100 0 000000 00009000 0000a000 0 0 0
0 0 0000b000 0000c000 000000 1 0 0 2 0 0000 0 000000 0000b000 0000c000 0 1 2
1 1 00010000 00020000 001000 0 0 0 0 0 1000 2 000000 00011000 00021000 0 0 0
1 2 ffffff00 00000300 7fffff 0 0 0 0 0 1fff 1 7fe000 00001eff 00000300 0 0 0
1 1 00000000 00000000 000010 0 0 0 0 0 0010 2 000000 00000010 00000010 0 0 0
2 2 00000400 00000800 000020 0 0 0 0 0 0008 0 000018 00000400 00000800 0 0 0
1 0 00000400 00000800 000020 1 0 1 0 0 0020 0 000000 00000420 00000800 0 0 0
1 1 00000100 00000200 000040 0 0 0 0 0 0010 1 000030 00000110 00000210 0 0 0

// ==== vlog.f ====
+incdir+.
dmaPkg.sv
queueCredits.sv
opUpdate.sv
transAckSeq.sv
dmaTransAck.sv
tb_dmaTransAck.sv

// ==== Makefile ====
TOP = tb_dmaTransAck
SIM = obj_dir/V$(TOP)

SRCS = dma_consts.svh dmaPkg.sv queueCredits.sv opUpdate.sv transAckSeq.sv \
       dmaTransAck.sv tb_dmaTransAck.sv

.PHONY: all run clean

all: run

$(SIM): $(SRCS) vlog.f
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vlog.f

run: $(SIM) dma_testdata.txt
	./$(SIM) | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
